// File: include/npc_defines.svh
`ifndef NPC_DEFINES_SVH
`define NPC_DEFINES_SVH

// RV32 data and address width.
`define NPC_XLEN 32

// first instruction fetched after reset.
`define NPC_RESET_PC 32'h8000_0000

// only uncompressed instructions are fetched, so every step is one word.
`define NPC_INST_LENGTH 32'd4

// ECALL and misaligned transfers land here.
`define NPC_TRAP_VECTOR 32'h8000_0420

`endif

// File: source/npc_pkg.sv
`default_nettype none
`include "npc_defines.svh"

package npc_pkg;

  typedef logic [`NPC_XLEN-1:0] addr_t;
  typedef logic [`NPC_XLEN-1:0] word_t;

  typedef enum logic [3:0] {
    NONE  = 4'd0,
    BEQ   = 4'd1,
    BNE   = 4'd2,
    BLT   = 4'd3,
    BGE   = 4'd4,
    BLTU  = 4'd5,
    BGEU  = 4'd6,
    JAL   = 4'd7,
    JALR  = 4'd8,
    MRET  = 4'd9,
    ECALL = 4'd10
  } tran_op_e; // codes 11 to 15 mean no transfer.

  typedef enum logic [2:0] {EQ, NE, LT, GE, LTU, GEU} cmp_kind_e;

  typedef enum logic {PC, OPERAND1} base_sel_e;

  typedef enum logic {IMM, INST_LENGTH} off_sel_e;

  typedef struct packed {
    tran_op_e op;
    word_t    operand1; // saved exception PC for MRET.
    word_t    operand2;
    word_t    imm;
  } exec_req_t;

  typedef struct packed {
    cmp_kind_e cmp_kind;
    base_sel_e base_sel;
    off_sel_e  off_sel;
    logic      is_branch;
    logic      uncond;
    logic      to_trap;
  } xfer_dec_t;

endpackage

`default_nettype wire

// File: source/branch_compare.sv
`default_nettype none
`timescale 1ns/1ps

module branch_compare (
  input  wire npc_pkg::cmp_kind_e cmp_kind_i,
  input  wire npc_pkg::word_t     operand1_i,
  input  wire npc_pkg::word_t     operand2_i,
  output logic                    taken_o
);
  import npc_pkg::*;

  localparam int unsigned MSB = $bits(word_t) - 1;

  logic  carry_out;
  word_t diff;
  logic  carry_flag;
  logic  zero_flag;
  logic  sign_flag;
  logic  overflow_flag;
  logic  equal;
  logic  signed_lt;
  logic  unsigned_lt;

  // operand1 minus operand2 as operand1 plus the inverse of operand2 plus one.
  assign {carry_out, diff} = {1'b0, operand1_i}
                           + {1'b0, ~operand2_i}
                           + {{($bits(word_t)){1'b0}}, 1'b1};

  assign carry_flag    = ~carry_out; // no carry out means a borrow happened.
  assign zero_flag     = ~(|diff);
  assign sign_flag     = diff[MSB];
  assign overflow_flag = (operand1_i[MSB] != operand2_i[MSB]) && (diff[MSB] != operand1_i[MSB]);

  assign equal       = zero_flag;
  assign signed_lt   = sign_flag ^ overflow_flag;
  assign unsigned_lt = carry_flag;

  always_comb begin
    case (cmp_kind_i)
      EQ:      taken_o = equal;
      NE:      taken_o = ~equal;
      LT:      taken_o = signed_lt;
      GE:      taken_o = ~signed_lt;
      LTU:     taken_o = unsigned_lt;
      GEU:     taken_o = ~unsigned_lt;
      default: taken_o = 1'b0;
    endcase
  end

  always_comb begin
    if (!$isunknown({operand1_i, operand2_i})) begin
      ult_check : assert final (unsigned_lt == (operand1_i < operand2_i))
        else $error("branch_compare: borrow flag disagrees with unsigned compare");
    end
  end

endmodule

`default_nettype wire

// File: source/target_adder.sv
`default_nettype none
`timescale 1ns/1ps
`include "npc_defines.svh"

module target_adder (
  input  wire npc_pkg::base_sel_e base_sel_i,
  input  wire npc_pkg::off_sel_e  off_sel_i,
  input  wire npc_pkg::addr_t     pc_i,
  input  wire npc_pkg::word_t     operand1_i,
  input  wire npc_pkg::word_t     imm_i,
  output npc_pkg::addr_t          seq_pc_o,
  output npc_pkg::addr_t          target_o
);
  import npc_pkg::*;

  addr_t base;
  addr_t offset;

  // fall-through address for untaken and idle cycles.
  assign seq_pc_o = pc_i + `NPC_INST_LENGTH;

  always_comb begin
    if (base_sel_i == OPERAND1) begin
      base = addr_t'(operand1_i); // JALR and MRET compute from a register.
    end else begin
      base = pc_i;
    end
  end

  always_comb begin
    if (off_sel_i == INST_LENGTH) begin
      offset = `NPC_INST_LENGTH;
    end else begin
      offset = addr_t'(imm_i);
    end
  end

  assign target_o = base + offset;

endmodule

`default_nettype wire

// File: source/pc_register.sv
`default_nettype none
`timescale 1ns/1ps
`include "npc_defines.svh"

module pc_register (
  input  wire            clk_i,
  input  wire            arst_n_i,
  input  wire npc_pkg::addr_t next_pc_i,
  input  wire            redirect_i,
  input  wire            misalign_i,
  output npc_pkg::addr_t pc_o,
  output logic           redirect_o,
  output logic           misalign_o
);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_o       <= `NPC_RESET_PC;
      redirect_o <= 1'b0;
      misalign_o <= 1'b0;
    end else begin
      pc_o       <= next_pc_i;
      redirect_o <= redirect_i; // pulses line up with the PC they describe.
      misalign_o <= misalign_i;
    end
  end

  // alignment holds only because control replaces misaligned targets.
  pc_aligned : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    pc_o[1:0] == 2'b00
  ) else $error("pc_register: fetch PC lost word alignment");

endmodule

`default_nettype wire

// File: source/npc_control.sv
`default_nettype none
`timescale 1ns/1ps
`include "npc_defines.svh"

module npc_control (
  input  wire                valid_i,
  input  wire npc_pkg::exec_req_t req_i,
  input  wire                taken_cond_i,
  input  wire npc_pkg::addr_t seq_pc_i,
  input  wire npc_pkg::addr_t target_i,
  output npc_pkg::cmp_kind_e cmp_kind_o,
  output npc_pkg::base_sel_e base_sel_o,
  output npc_pkg::off_sel_e  off_sel_o,
  output npc_pkg::addr_t     next_pc_o,
  output logic               redirect_o,
  output logic               misalign_o
);
  import npc_pkg::*;

  xfer_dec_t dec;
  logic      taken;
  logic      target_misaligned;

  function automatic xfer_dec_t decode(input tran_op_e op);
    xfer_dec_t d;
    case (op)
      BEQ:     d.cmp_kind = EQ;
      BNE:     d.cmp_kind = NE;
      BLT:     d.cmp_kind = LT;
      BGE:     d.cmp_kind = GE;
      BLTU:    d.cmp_kind = LTU;
      BGEU:    d.cmp_kind = GEU;
      default: d.cmp_kind = EQ;
    endcase
    d.is_branch = op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU};
    d.uncond    = op inside {JAL, JALR, MRET, ECALL};
    d.to_trap   = (op == ECALL);
    d.base_sel  = (op inside {JALR, MRET}) ? OPERAND1 : PC;
    d.off_sel   = (op == MRET) ? INST_LENGTH : IMM; // MRET resumes after the saved PC.
    return d;
  endfunction

  assign dec = decode(req_i.op);

  assign cmp_kind_o = dec.cmp_kind;
  assign base_sel_o = dec.base_sel;
  assign off_sel_o  = dec.off_sel;

  assign taken = valid_i && (dec.uncond || (dec.is_branch && taken_cond_i));

  // the trap vector itself is aligned, so ECALL never counts as misaligned.
  assign target_misaligned = !dec.to_trap && (target_i[1:0] != 2'b00);

  always_comb begin
    if (!taken) begin
      next_pc_o = seq_pc_i;
    end else if (dec.to_trap || target_misaligned) begin
      next_pc_o = `NPC_TRAP_VECTOR;
    end else begin
      next_pc_o = target_i;
    end
  end

  assign redirect_o = taken; // trap entry is a redirect as well.
  assign misalign_o = taken && target_misaligned;

endmodule

`default_nettype wire

// File: source/npc_unit.sv
`default_nettype none
`timescale 1ns/1ps

module npc_unit (
  input  wire                     clk_i,
  input  wire                     arst_n_i,
  input  wire                     valid_i,
  input  wire npc_pkg::exec_req_t req_i,
  output npc_pkg::addr_t          pc_o,
  output logic                    redirect_o,
  output logic                    misalign_o
);
  import npc_pkg::*;

  cmp_kind_e cmp_kind;
  base_sel_e base_sel;
  off_sel_e  off_sel;
  logic      taken_cond;
  addr_t     seq_pc;
  addr_t     target;
  addr_t     next_pc;
  logic      load_redirect;
  logic      load_misalign;

  npc_control npc_control_inst (
    .valid_i      (valid_i),
    .req_i        (req_i),
    .taken_cond_i (taken_cond),
    .seq_pc_i     (seq_pc),
    .target_i     (target),
    .cmp_kind_o   (cmp_kind),
    .base_sel_o   (base_sel),
    .off_sel_o    (off_sel),
    .next_pc_o    (next_pc),
    .redirect_o   (load_redirect),
    .misalign_o   (load_misalign)
  );

  branch_compare branch_compare_inst (
    .cmp_kind_i (cmp_kind),
    .operand1_i (req_i.operand1),
    .operand2_i (req_i.operand2),
    .taken_o    (taken_cond)
  );

  target_adder target_adder_inst (
    .base_sel_i (base_sel),
    .off_sel_i  (off_sel),
    .pc_i       (pc_o), // requests always refer to the instruction at the current PC.
    .operand1_i (req_i.operand1),
    .imm_i      (req_i.imm),
    .seq_pc_o   (seq_pc),
    .target_o   (target)
  );

  pc_register pc_register_inst (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .next_pc_i  (next_pc),
    .redirect_i (load_redirect),
    .misalign_i (load_misalign),
    .pc_o       (pc_o),
    .redirect_o (redirect_o),
    .misalign_o (misalign_o)
  );

endmodule

`default_nettype wire

// File: verification/npc_unit_tb.sv
`default_nettype none
`timescale 1ns/1ps
`include "npc_defines.svh"

module npc_unit_tb;
  import npc_pkg::*;

  localparam int unsigned TOTAL_CYCLES = 2 + 1 + 16 + 300 + 100 + 100 + 100 + 2000;
  localparam int unsigned WATCHDOG_NS  = (TOTAL_CYCLES + 200) * 8;

  logic      clk_i;
  logic      arst_n_i;
  logic      valid_i;
  exec_req_t req_i;
  addr_t     pc_o;
  logic      redirect_o;
  logic      misalign_o;

  addr_t     model_pc; // PC the DUT should be fetching from.
  int        checks_done;

  npc_unit npc_unit_inst (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .valid_i    (valid_i),
    .req_i      (req_i),
    .pc_o       (pc_o),
    .redirect_o (redirect_o),
    .misalign_o (misalign_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  initial begin
    #(WATCHDOG_NS);
    fail_run("timeout: the run did not finish in the expected number of cycles");
  end

  function automatic word_t pick_operand();
    case ($urandom % 8)
      0: return 32'h0000_0000;
      1: return 32'h7fff_ffff; // largest positive value.
      2: return 32'h8000_0000;
      3: return 32'hffff_ffff;
      4: return 32'h0000_0001;
      default: return word_t'($urandom);
    endcase
  endfunction

  function automatic word_t pick_imm(input bit aligned);
    word_t imm;
    imm = word_t'($urandom_range(4095, 0)) << 2;
    if ($urandom % 2 == 1) begin
      imm = ~imm + 32'd1;
    end
    if (!aligned) begin
      imm = imm | word_t'($urandom_range(3, 1));
    end
    return imm;
  endfunction

  function automatic exec_req_t make_request(input tran_op_e op, input bit aligned);
    exec_req_t req;
    req.op       = op;
    req.operand1 = pick_operand();
    req.operand2 = ($urandom % 4 == 0) ? req.operand1 : pick_operand();
    req.imm      = pick_imm(aligned);
    return req;
  endfunction

  task automatic check_outputs(input addr_t exp_pc, input logic exp_redirect,
                               input logic exp_misalign);
    pc_check : assert (pc_o === exp_pc)
      else fail_run($sformatf("mismatch at %0t: pc_o %h, expected %h", $time, pc_o, exp_pc));
    redirect_check : assert (redirect_o === exp_redirect)
      else fail_run($sformatf("mismatch at %0t: redirect_o %b, expected %b",
                              $time, redirect_o, exp_redirect));
    misalign_check : assert (misalign_o === exp_misalign)
      else fail_run($sformatf("mismatch at %0t: misalign_o %b, expected %b",
                              $time, misalign_o, exp_misalign));
    checks_done++;
  endtask

  task automatic drive_and_check(input logic valid, input exec_req_t req);
    logic  taken;
    logic  exp_misalign;
    addr_t target;
    addr_t exp_pc;
    taken  = 1'b0;
    target = model_pc + req.imm;
    if (valid) begin
      case (req.op)
        BEQ:     taken = (req.operand1 == req.operand2);
        BNE:     taken = (req.operand1 != req.operand2);
        BLT:     taken = ($signed(req.operand1) < $signed(req.operand2));
        BGE:     taken = ($signed(req.operand1) >= $signed(req.operand2));
        BLTU:    taken = (req.operand1 < req.operand2);
        BGEU:    taken = (req.operand1 >= req.operand2);
        JAL:     taken = 1'b1;
        JALR: begin
          taken  = 1'b1;
          target = req.operand1 + req.imm;
        end
        MRET: begin
          taken  = 1'b1;
          target = req.operand1 + `NPC_INST_LENGTH; // resume after the saved PC.
        end
        ECALL: begin
          taken  = 1'b1;
          target = `NPC_TRAP_VECTOR;
        end
        default: taken = 1'b0;
      endcase
    end
    exp_misalign = taken && (target[1:0] != 2'b00);
    exp_pc = !taken ? model_pc + `NPC_INST_LENGTH : (exp_misalign ? `NPC_TRAP_VECTOR : target);
    valid_i = valid;
    req_i   = req;
    @(posedge clk_i);
    #1;
    check_outputs(exp_pc, taken, exp_misalign);
    model_pc = exp_pc;
  endtask

  initial begin
    exec_req_t req;
    int        kind;
    void'($urandom(62013));
    arst_n_i    = 1'b0;
    valid_i     = 1'b0;
    req_i       = '0;
    checks_done = 0;
    model_pc    = `NPC_RESET_PC;
    repeat (2) @(posedge clk_i);
    #1 arst_n_i = 1'b1;
    check_outputs(`NPC_RESET_PC, 1'b0, 1'b0);
    repeat (16) begin
      drive_and_check(1'b0, make_request(tran_op_e'(4'($urandom_range(15, 0))), 1'b1));
    end
    repeat (300) begin
      drive_and_check(1'b1, make_request(tran_op_e'(4'($urandom_range(6, 1))), 1'b1));
    end
    repeat (100) begin
      req = make_request(($urandom % 2 == 0) ? JAL : JALR, 1'b1);
      req.operand1[1:0] = 2'b00;
      drive_and_check(1'b1, req);
    end
    repeat (100) begin
      req = make_request(tran_op_e'(4'($urandom_range(15, 9))), 1'b1); // MRET, ECALL or unused.
      req.operand1[1:0] = 2'b00;
      drive_and_check(1'b1, req);
    end
    repeat (100) begin
      kind = int'($urandom % 4);
      req  = make_request(JAL, 1'b0);
      if (kind == 1) begin
        req.op            = JALR;
        req.operand1[1:0] = 2'b00;
      end else if (kind == 2) begin
        req.op            = MRET;
        req.operand1[1:0] = 2'(($urandom % 3) + 1);
      end else if (kind == 3) begin
        req.op       = BEQ;
        req.operand2 = req.operand1; // force the branch to be taken.
      end
      drive_and_check(1'b1, req);
    end
    repeat (2000) begin
      req = make_request(tran_op_e'(4'($urandom_range(15, 0))), ($urandom % 8) != 0);
      drive_and_check(($urandom % 4) != 0, req);
    end
    $display("checked %0d cycles", checks_done);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
source/npc_pkg.sv
source/branch_compare.sv
source/target_adder.sv
source/pc_register.sv
source/npc_control.sv
source/npc_unit.sv
verification/npc_unit_tb.sv

// File: Makefile
# Verilator build and run of the next-PC unit testbench.
# The simulator exits with a failing status when the testbench stops with $fatal.

TB_TOP := npc_unit_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f src.f --top-module $(TB_TOP) -o $(TB_TOP)
	./obj_dir/$(TB_TOP)

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module $(TB_TOP)
	verilator --lint-only -Wall +incdir+include source/npc_pkg.sv source/branch_compare.sv \
	  source/target_adder.sv source/pc_register.sv source/npc_control.sv \
	  source/npc_unit.sv --top-module npc_unit

clean:
	rm -rf obj_dir
